//--- Bender.yml
package:
  name: ulpi_usb_rx

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/usb_rx_pkg.sv
      - rtl/ulpi_rx_capture.sv
      - rtl/usb_pid_decode.sv
      - rtl/usb_token_check.sv
      - rtl/usb_bulk_out_sink.sv
      - rtl/ulpi_usb_rx.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_ulpi_usb_rx.sv

//--- project.f
+incdir+rtl
rtl/usb_rx_pkg.sv
rtl/ulpi_rx_capture.sv
rtl/usb_pid_decode.sv
rtl/usb_token_check.sv
rtl/usb_bulk_out_sink.sv
rtl/ulpi_usb_rx.sv
test/tb_ulpi_usb_rx.sv

//--- rtl/ulpi_rx_capture.sv
`include "usb_rx_consts.svh"

module ulpi_rx_capture (
  input  logic                   clock,
  input  logic                   areset_n,
  input  logic                   ulpi_dir_i,
  input  logic                   ulpi_nxt_i,
  input  logic [`USB_BYTE_W-1:0] ulpi_data_i,
  output usb_rx_pkg::rx_byte_t   byte_o
);

  logic                   dir_q;         // dir one cycle back, marks turnaround
  logic                   hold_vld_q;    // a data byte is in hand
  logic                   hold_first_q;
  logic [`USB_BYTE_W-1:0] hold_data_q;
  logic                   first_pend_q;  // next data byte opens a packet
  logic                   rx_data;
  logic                   rx_cmd;
  logic                   rx_end;

  // turnaround cycle has dir high but dir_q low, so it is ignored
  assign rx_data = ulpi_dir_i & dir_q & ulpi_nxt_i;
  assign rx_cmd  = ulpi_dir_i & dir_q & ~ulpi_nxt_i;  // rx cmd byte on the bus

  // packet over when the phy gives the bus back or RxActive (bit 4) clears
  assign rx_end = (dir_q & ~ulpi_dir_i) | (rx_cmd & ~ulpi_data_i[4]);

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      dir_q        <= 1'b0;
      hold_vld_q   <= 1'b0;
      hold_first_q <= 1'b0;
      first_pend_q <= 1'b1;
      byte_o       <= '0;
    end else begin
      dir_q        <= ulpi_dir_i;
      byte_o.valid <= 1'b0;  // strobe
      byte_o.last  <= 1'b0;
      if (rx_data) begin
        // new byte pushes the held one out
        if (hold_vld_q) begin
          byte_o.valid <= 1'b1;
          byte_o.data  <= hold_data_q;
          byte_o.first <= hold_first_q;
        end
        hold_vld_q   <= 1'b1;
        hold_first_q <= first_pend_q;
        first_pend_q <= 1'b0;
      end else if (rx_end) begin
        // flush the held byte as the packet's last
        if (hold_vld_q) begin
          byte_o.valid <= 1'b1;
          byte_o.data  <= hold_data_q;
          byte_o.first <= hold_first_q;
          byte_o.last  <= 1'b1;
        end
        hold_vld_q   <= 1'b0;
        first_pend_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rx_data) begin
      hold_data_q <= ulpi_data_i;
    end
  end

  // phy must not signal nxt while it turns the bus around
  a_no_nxt_in_turnaround : assert property (
    @(posedge clock) disable iff (!areset_n)
    (ulpi_dir_i && !$past(ulpi_dir_i)) |-> !ulpi_nxt_i
  ) else $error("ulpi nxt high in turnaround cycle");

endmodule

//--- rtl/ulpi_usb_rx.sv
`include "usb_rx_consts.svh"

module ulpi_usb_rx (
  input  logic                   clock,
  input  logic                   areset_n,
  input  logic [6:0]             dev_addr_i,
  // ulpi receive side
  input  logic                   ulpi_dir_i,
  input  logic                   ulpi_nxt_i,
  input  logic [`USB_BYTE_W-1:0] ulpi_data_i,
  // bulk out payload stream
  output logic                   m_axis_tvalid_o,
  input  logic                   m_axis_tready_i,
  output logic                   m_axis_tlast_o,
  output logic [`USB_BYTE_W-1:0] m_axis_tdata_o,
  output logic                   blk_start_o,
  output logic [`USB_EP_W-1:0]   blk_endpt_o,
  // status
  output logic                   sof_o,
  output logic [10:0]            sof_frame_o,
  output logic                   pid_err_o,
  output logic                   crc_err_o,
  output logic                   overflow_o
);

  import usb_rx_pkg::*;

  rx_byte_t   rx_byte;      // capture to pid stage
  pid_byte_t  pid_byte;     // pid to token stage
  data_byte_t data_byte;    // token stage to sink
  logic       tok_crc_err;  // crc5
  logic       blk_crc_err;  // crc16

  ulpi_rx_capture u_capture (
    .clock       (clock),
    .areset_n    (areset_n),
    .ulpi_dir_i  (ulpi_dir_i),
    .ulpi_nxt_i  (ulpi_nxt_i),
    .ulpi_data_i (ulpi_data_i),
    .byte_o      (rx_byte)
  );

  usb_pid_decode u_pid (
    .clock     (clock),
    .areset_n  (areset_n),
    .byte_i    (rx_byte),
    .pid_o     (pid_byte),
    .pid_err_o (pid_err_o)
  );

  usb_token_check u_token (
    .clock       (clock),
    .areset_n    (areset_n),
    .dev_addr_i  (dev_addr_i),
    .pid_i       (pid_byte),
    .data_o      (data_byte),
    .sof_o       (sof_o),
    .sof_frame_o (sof_frame_o),
    .crc_err_o   (tok_crc_err)
  );

  usb_bulk_out_sink u_sink (
    .clock           (clock),
    .areset_n        (areset_n),
    .data_i          (data_byte),
    .m_axis_tvalid_o (m_axis_tvalid_o),
    .m_axis_tready_i (m_axis_tready_i),
    .m_axis_tlast_o  (m_axis_tlast_o),
    .m_axis_tdata_o  (m_axis_tdata_o),
    .blk_start_o     (blk_start_o),
    .blk_endpt_o     (blk_endpt_o),
    .crc_err_o       (blk_crc_err),
    .overflow_o      (overflow_o)
  );

  // token and data crc errors never fall in the same cycle
  assign crc_err_o = tok_crc_err | blk_crc_err;

endmodule

//--- rtl/usb_bulk_out_sink.sv
`include "usb_rx_consts.svh"

module usb_bulk_out_sink (
  input  logic                   clock,
  input  logic                   areset_n,
  input  usb_rx_pkg::data_byte_t data_i,
  output logic                   m_axis_tvalid_o,
  input  logic                   m_axis_tready_i,
  output logic                   m_axis_tlast_o,
  output logic [`USB_BYTE_W-1:0] m_axis_tdata_o,
  output logic                   blk_start_o,
  output logic [`USB_EP_W-1:0]   blk_endpt_o,
  output logic                   crc_err_o,
  output logic                   overflow_o
);

  logic [15:0]            crc16_q;
  logic [15:0]            crc16_nxt;
  logic [`USB_BYTE_W-1:0] win0_q;        // older byte of the window
  logic [`USB_BYTE_W-1:0] win1_q;
  logic [1:0]             fill_q;        // bytes in the window
  logic                   start_pend_q;  // first beat of packet not yet sent
  logic                   body;          // byte after the pid
  logic                   beat;

  function automatic logic [15:0] crc16_byte(input logic [15:0] crc, input logic [7:0] b);
    logic [15:0] c;
    int          i;
    c = crc;
    for (i = 0; i < 8; i++) begin
      if (c[15] ^ b[i])
        c = {c[14:0], 1'b0} ^ `USB_CRC16_POLY;
      else
        c = {c[14:0], 1'b0};
    end
    return c;
  endfunction

  assign body      = data_i.valid & ~data_i.first;
  assign beat      = body & (fill_q == 2'd2);  // full window means oldest byte is payload
  assign crc16_nxt = crc16_byte(crc16_q, data_i.data);

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      crc16_q         <= '1;
      fill_q          <= 2'd0;
      start_pend_q    <= 1'b0;
      m_axis_tvalid_o <= 1'b0;
      m_axis_tlast_o  <= 1'b0;
      blk_start_o     <= 1'b0;
      blk_endpt_o     <= '0;
      crc_err_o       <= 1'b0;
      overflow_o      <= 1'b0;
    end else begin
      if (data_i.valid && data_i.first) begin
        crc16_q      <= '1;  // pid byte is not covered
        fill_q       <= 2'd0;
        start_pend_q <= 1'b1;
      end else if (body) begin
        crc16_q <= crc16_nxt;
        if (data_i.last) fill_q <= 2'd0;  // window left holding the crc
        else if (fill_q != 2'd2) fill_q <= fill_q + 2'd1;
        if (beat) start_pend_q <= 1'b0;
      end

      m_axis_tvalid_o <= beat;
      m_axis_tlast_o  <= beat & data_i.last;
      blk_start_o     <= beat & start_pend_q;
      if (beat && start_pend_q) blk_endpt_o <= data_i.endpt;

      // pid-only data packet is malformed too
      crc_err_o <= data_i.valid & data_i.last &
                   (data_i.first | (crc16_nxt != `USB_CRC16_RESIDUE));

      if (m_axis_tvalid_o && !m_axis_tready_i) overflow_o <= 1'b1;  // sticky
    end
  end

  always_ff @(posedge clock) begin
    if (body) begin
      win0_q <= win1_q;
      win1_q <= data_i.data;
    end
    if (beat) m_axis_tdata_o <= win0_q;
  end

  // tlast rides on a beat and closes the packet so no beat follows at once
  a_tlast_with_tvalid : assert property (
    @(posedge clock) disable iff (!areset_n)
    m_axis_tlast_o |-> m_axis_tvalid_o ##1 !m_axis_tvalid_o
  ) else $error("tlast without tvalid or beat right after packet end");

endmodule

//--- rtl/usb_pid_decode.sv
`include "usb_rx_consts.svh"

module usb_pid_decode (
  input  logic                  clock,
  input  logic                  areset_n,
  input  usb_rx_pkg::rx_byte_t  byte_i,
  output usb_rx_pkg::pid_byte_t pid_o,
  output logic                  pid_err_o
);

  import usb_rx_pkg::*;

  logic      pass_q;    // current packet had a good pid
  usb_pid_e  pid_q;     // tag for the rest of the packet
  usb_kind_e kind_q;
  logic      pid_ok;
  usb_pid_e  pid_now;
  usb_kind_e kind_now;

  // high nibble carries the inverted pid
  assign pid_ok = (byte_i.data[7:4] == ~byte_i.data[3:0]);

  // reserved codes pass through as raw values
  assign pid_now  = usb_pid_e'(byte_i.data[3:0]);
  assign kind_now = usb_kind_e'(byte_i.data[1:0]);

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      pass_q    <= 1'b0;
      pid_q     <= PID_OUT;
      kind_q    <= KIND_SPECIAL;
      pid_o     <= '0;
      pid_err_o <= 1'b0;
    end else begin
      pid_o.valid <= 1'b0;
      pid_err_o   <= 1'b0;

      if (byte_i.valid) begin
        pid_o.data  <= byte_i.data;
        pid_o.first <= byte_i.first;
        pid_o.last  <= byte_i.last;
      end

      if (byte_i.valid && byte_i.first) begin
        pid_o.valid <= pid_ok;
        pid_o.pid   <= pid_now;
        pid_o.kind  <= kind_now;
        pid_q       <= pid_now;
        kind_q      <= kind_now;
        pid_err_o   <= ~pid_ok;             // one pulse per bad packet
        pass_q      <= pid_ok & ~byte_i.last;  // pid-only packets close here
      end else if (byte_i.valid) begin
        pid_o.valid <= pass_q;  // bad pid swallows the whole packet
        pid_o.pid   <= pid_q;
        pid_o.kind  <= kind_q;
        if (byte_i.last) begin
          pass_q <= 1'b0;
        end
      end
    end
  end

endmodule

//--- rtl/usb_rx_consts.svh
`ifndef USB_RX_CONSTS_SVH
`define USB_RX_CONSTS_SVH

// ulpi data bus and usb byte width
`define USB_BYTE_W 8

// token crc polynomial x^5 + x^2 + 1
// register starts at all ones and is shifted msb out
`define USB_CRC5_POLY 5'b00101

// remainder left after a token and its inverted crc5 went through
`define USB_CRC5_RESIDUE 5'b01100

// data crc polynomial x^16 + x^15 + x^2 + 1
`define USB_CRC16_POLY 16'h8005

// remainder of a good data packet including its crc16 bytes
`define USB_CRC16_RESIDUE 16'h800d

// endpoint field of a token, 16 endpoints
`define USB_EP_W 4

`endif

//--- rtl/usb_rx_pkg.sv
`include "usb_rx_consts.svh"

package usb_rx_pkg;

  // pid codes as they appear in the low nibble of the pid byte
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SOF   = 4'b0101,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110
  } usb_pid_e;

  // packet kind is pid[1:0] directly
  typedef enum logic [1:0] {
    KIND_SPECIAL = 2'b00,
    KIND_TOKEN   = 2'b01,
    KIND_HSK     = 2'b10,
    KIND_DATA    = 2'b11
  } usb_kind_e;

  // capture stage output
  typedef struct packed {
    logic                   valid;
    logic [`USB_BYTE_W-1:0] data;
    logic                   first;  // pid byte
    logic                   last;
  } rx_byte_t;

  // pid stage output, every byte tagged
  typedef struct packed {
    logic                   valid;
    logic [`USB_BYTE_W-1:0] data;
    logic                   first;
    logic                   last;
    usb_pid_e               pid;
    usb_kind_e              kind;
  } pid_byte_t;

  // token stage output, armed data packets only
  typedef struct packed {
    logic                   valid;
    logic [`USB_BYTE_W-1:0] data;
    logic                   first;
    logic                   last;
    logic [`USB_EP_W-1:0]   endpt;  // from the OUT token
  } data_byte_t;

endpackage

//--- rtl/usb_token_check.sv
`include "usb_rx_consts.svh"

module usb_token_check (
  input  logic                   clock,
  input  logic                   areset_n,
  input  logic [6:0]             dev_addr_i,
  input  usb_rx_pkg::pid_byte_t  pid_i,
  output usb_rx_pkg::data_byte_t data_o,
  output logic                   sof_o,
  output logic [10:0]            sof_frame_o,
  output logic                   crc_err_o
);

  import usb_rx_pkg::*;

  logic [4:0]             crc5_q;
  logic [4:0]             crc5_nxt;
  logic [1:0]             cnt_q;     // token bytes seen after the pid
  logic [`USB_BYTE_W-1:0] tok_lo_q;  // addr and endp[0], or frame[7:0]
  logic                   armed_q;
  logic [`USB_EP_W-1:0]   endpt_q;
  logic                   tok_byte;
  logic                   tok_end;
  logic                   tok_good;
  logic                   arm_hit;

  // serial crc5 with bits entering lsb first
  function automatic logic [4:0] crc5_byte(input logic [4:0] crc, input logic [7:0] b);
    logic [4:0] c;
    int         i;
    c = crc;
    for (i = 0; i < 8; i++) begin
      if (c[4] ^ b[i])
        c = {c[3:0], 1'b0} ^ `USB_CRC5_POLY;
      else
        c = {c[3:0], 1'b0};
    end
    return c;
  endfunction

  assign tok_byte = pid_i.valid & (pid_i.kind == KIND_TOKEN) & ~pid_i.first;
  assign tok_end  = pid_i.valid & (pid_i.kind == KIND_TOKEN) & pid_i.last;
  assign crc5_nxt = crc5_byte(crc5_q, pid_i.data);

  // pid plus exactly two field bytes and a clean remainder
  assign tok_good = tok_end & ~pid_i.first & (cnt_q == 2'd1) &
                    (crc5_nxt == `USB_CRC5_RESIDUE);
  assign arm_hit  = tok_good & (pid_i.pid == PID_OUT) & (tok_lo_q[6:0] == dev_addr_i);

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      crc5_q      <= '1;
      cnt_q       <= 2'd0;
      tok_lo_q    <= '0;
      armed_q     <= 1'b0;
      endpt_q     <= '0;
      data_o      <= '0;
      sof_o       <= 1'b0;
      sof_frame_o <= '0;
      crc_err_o   <= 1'b0;
    end else begin
      if (pid_i.valid && pid_i.first) begin
        crc5_q <= '1;
        cnt_q  <= 2'd0;
      end else if (tok_byte) begin
        crc5_q <= crc5_nxt;
        if (cnt_q != 2'd3) cnt_q <= cnt_q + 2'd1;  // saturate on long tokens
        if (cnt_q == 2'd0) tok_lo_q <= pid_i.data;
      end

      // arm lasts until the end of the next packet
      if (pid_i.valid && pid_i.last) begin
        armed_q <= arm_hit;
      end
      if (arm_hit) endpt_q <= {pid_i.data[2:0], tok_lo_q[7]};

      crc_err_o <= tok_end & ~tok_good;  // also catches short tokens
      sof_o     <= tok_good & (pid_i.pid == PID_SOF);
      if (tok_good && pid_i.pid == PID_SOF) sof_frame_o <= {pid_i.data[2:0], tok_lo_q};

      data_o.valid <= pid_i.valid & (pid_i.kind == KIND_DATA) & armed_q;
      data_o.data  <= pid_i.data;
      data_o.first <= pid_i.first;
      data_o.last  <= pid_i.last;
      data_o.endpt <= endpt_q;
    end
  end

  // bytes inside a forwarded packet still see the arm held
  a_fwd_only_armed : assert property (
    @(posedge clock) disable iff (!areset_n)
    data_o.valid && !data_o.last |-> armed_q
  ) else $error("data byte forwarded after the arm dropped");

endmodule

//--- test/tb_ulpi_usb_rx.sv
`include "usb_rx_consts.svh"

module tb_ulpi_usb_rx;

  timeunit 1ns;
  timeprecision 100ps;

  import usb_rx_pkg::*;

  localparam logic [6:0] DEV_ADDR = 7'h2b;
  // 15 packets of roughly 30 cycles plus settle waits come to about 700 cycles
  localparam int CYCLE_LIMIT = 4000;

  logic                   clock;
  logic                   areset_n;
  logic                   ulpi_dir;
  logic                   ulpi_nxt;
  logic [`USB_BYTE_W-1:0] ulpi_data;
  logic                   m_axis_tvalid_o;
  logic                   m_axis_tready;
  logic                   m_axis_tlast_o;
  logic [`USB_BYTE_W-1:0] m_axis_tdata_o;
  logic                   blk_start_o;
  logic [`USB_EP_W-1:0]   blk_endpt_o;
  logic                   sof_o;
  logic [10:0]            sof_frame_o;
  logic                   pid_err_o;
  logic                   crc_err_o;
  logic                   overflow_o;

  integer                 seed = 32'ha229a411;
  int                     cycle_cnt = 0;
  string                  test_name = "reset";
  logic [7:0]             pkt[$];       // bytes of the next ulpi packet
  logic [7:0]             exp_q[$];     // expected payload
  logic [7:0]             beat_q[$];    // collected m_axis beats
  int                     tlast_q[$];   // beat index of each tlast
  logic [`USB_EP_W-1:0]   endpt_q[$];   // blk_endpt_o at each blk_start_o
  logic [10:0]            frame_q[$];
  int                     crc_cnt;
  int                     pid_cnt;

  ulpi_usb_rx ulpi_usb_rx_i (
    .clock           (clock),
    .areset_n        (areset_n),
    .dev_addr_i      (DEV_ADDR),
    .ulpi_dir_i      (ulpi_dir),
    .ulpi_nxt_i      (ulpi_nxt),
    .ulpi_data_i     (ulpi_data),
    .m_axis_tvalid_o (m_axis_tvalid_o),
    .m_axis_tready_i (m_axis_tready),
    .m_axis_tlast_o  (m_axis_tlast_o),
    .m_axis_tdata_o  (m_axis_tdata_o),
    .blk_start_o     (blk_start_o),
    .blk_endpt_o     (blk_endpt_o),
    .sof_o           (sof_o),
    .sof_frame_o     (sof_frame_o),
    .pid_err_o       (pid_err_o),
    .crc_err_o       (crc_err_o),
    .overflow_o      (overflow_o)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;  // 20 ns
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  always @(posedge clock) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT)
      stop_with_error($sformatf("Timeout: run went past %0d cycles in %s",
                                CYCLE_LIMIT, test_name));
  end

  // sampled half a cycle after the driving edge
  always @(negedge clock) begin
    if (areset_n) begin
      if (m_axis_tvalid_o && m_axis_tready) begin
        beat_q.push_back(m_axis_tdata_o);
        if (m_axis_tlast_o) tlast_q.push_back(beat_q.size() - 1);
      end
      if (blk_start_o) endpt_q.push_back(blk_endpt_o);
      if (sof_o) frame_q.push_back(sof_frame_o);
      if (crc_err_o) crc_cnt++;
      if (pid_err_o) pid_cnt++;
    end
  end

  task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act)
      stop_with_error($sformatf("Mismatch in %s, %s: expected 0x%02h, actual 0x%02h",
                                test_name, what, exp, act));
  endtask

  task automatic check_endpt(input logic [`USB_EP_W-1:0] exp, input logic [`USB_EP_W-1:0] act);
    if (exp !== act)
      stop_with_error($sformatf("Mismatch in %s, endpoint: expected %0d, actual %0d",
                                test_name, exp, act));
  endtask

  task automatic check_frame(input logic [10:0] exp, input logic [10:0] act);
    if (exp !== act)
      stop_with_error($sformatf("Mismatch in %s, frame: expected 0x%03h, actual 0x%03h",
                                test_name, exp, act));
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act)
      stop_with_error($sformatf("Mismatch in %s, %s: expected %b, actual %b",
                                test_name, what, exp, act));
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (exp != act)
      stop_with_error($sformatf("Mismatch in %s, %s: expected %0d, actual %0d",
                                test_name, what, exp, act));
  endtask

  // x^5+x^2+1 over the 11 field bits lsb first and sent inverted msb first
  function automatic logic [4:0] crc5_bits(input logic [10:0] field);
    logic [4:0] c;
    logic [4:0] r;
    logic       fb;
    int         i;
    c = 5'h1f;
    for (i = 0; i < 11; i++) begin
      fb = c[4] ^ field[i];
      c  = {c[3:0], 1'b0};
      if (fb) c = c ^ 5'b00101;
    end
    for (i = 0; i < 5; i++) r[i] = ~c[4-i];  // wire order in byte bits 3..7
    return r;
  endfunction

  // x^16+x^15+x^2+1 over exp_q giving {second byte, first byte} as sent
  function automatic logic [15:0] crc16_bits();
    logic [15:0] c;
    logic [15:0] r;
    logic        fb;
    int          i;
    c = 16'hffff;
    foreach (exp_q[j]) begin
      for (i = 0; i < 8; i++) begin
        fb = c[15] ^ exp_q[j][i];
        c  = {c[14:0], 1'b0};
        if (fb) c = c ^ 16'h8005;
      end
    end
    for (i = 0; i < 16; i++) r[i] = ~c[15-i];
    return r;
  endfunction

  function automatic logic [7:0] pid_byte(input usb_pid_e p);
    return {~p, p};  // check nibble on top
  endfunction

  task automatic build_token(input usb_pid_e p, input logic [10:0] field);
    pkt.delete();
    pkt.push_back(pid_byte(p));
    pkt.push_back(field[7:0]);
    pkt.push_back({crc5_bits(field), field[10:8]});
  endtask

  // flip_idx >= 0 spoils one byte after the crc is taken
  task automatic build_data(input usb_pid_e p, input int flip_idx);
    logic [15:0] crc;
    crc = crc16_bits();
    if (flip_idx >= 0) exp_q[flip_idx] = exp_q[flip_idx] ^ 8'h20;
    pkt.delete();
    pkt.push_back(pid_byte(p));
    foreach (exp_q[i]) pkt.push_back(exp_q[i]);
    pkt.push_back(crc[7:0]);
    pkt.push_back(crc[15:8]);
  endtask

  task automatic random_payload();
    int len;
    len = ($random(seed) & 15) + 1;  // 1..16 bytes
    exp_q.delete();
    repeat (len) exp_q.push_back($random(seed));
  endtask

  // dir up, turnaround, data with nxt and random rx cmd gaps, dir down
  task automatic send_ulpi_packet();
    int i;
    i = 0;
    @(posedge clock);
    ulpi_dir  <= 1'b1;
    ulpi_nxt  <= 1'b0;
    ulpi_data <= 8'h00;
    while (i < pkt.size()) begin
      @(posedge clock);
      if (($random(seed) & 3) == 0) begin
        ulpi_nxt  <= 1'b0;
        ulpi_data <= 8'h10 | ($random(seed) & 8'h03);  // RxActive kept high
      end else begin
        ulpi_nxt  <= 1'b1;
        ulpi_data <= pkt[i];
        i++;
      end
    end
    @(posedge clock);
    ulpi_dir  <= 1'b0;
    ulpi_nxt  <= 1'b0;
    ulpi_data <= 8'h00;
    repeat (2) @(posedge clock);  // bus idle gap
  endtask

  task automatic clear_monitor();
    beat_q.delete();
    tlast_q.delete();
    endpt_q.delete();
    frame_q.delete();
    crc_cnt = 0;
    pid_cnt = 0;
  endtask

  // covers the fixed 4-cycle latency after a packet end with margin
  task automatic settle();
    repeat (8) @(posedge clock);
  endtask

  task automatic wait_for_tlast();
    while (tlast_q.size() == 0) @(negedge clock);
    settle();
  endtask

  task automatic check_payload(input logic [`USB_EP_W-1:0] ep);
    check_count("beat count", exp_q.size(), beat_q.size());
    foreach (exp_q[i]) check_byte($sformatf("beat %0d", i), exp_q[i], beat_q[i]);
    if (tlast_q.size() != 1 || tlast_q[0] != exp_q.size() - 1)
      stop_with_error($sformatf("tlast missing or not on the final beat in %s", test_name));
    if (endpt_q.size() != 1)
      stop_with_error($sformatf("expected one blk_start_o pulse in %s, saw %0d",
                                test_name, endpt_q.size()));
    check_endpt(ep, endpt_q[0]);
  endtask

  task automatic send_out_data(input usb_pid_e p, input int flip_idx);
    build_token(PID_OUT, {4'd2, DEV_ADDR});
    send_ulpi_packet();
    build_data(p, flip_idx);
    send_ulpi_packet();
  endtask

  task automatic test_out_data();
    test_name = "out_data0";
    clear_monitor();
    random_payload();
    send_out_data(PID_DATA0, -1);
    wait_for_tlast();
    check_payload(4'd2);
    check_count("crc_err pulses", 0, crc_cnt);
    check_count("pid_err pulses", 0, pid_cnt);
  endtask

  task automatic test_token_reject();
    test_name = "bad_crc5";
    clear_monitor();
    build_token(PID_OUT, {4'd2, DEV_ADDR});
    pkt[2] = pkt[2] ^ 8'h08;  // first crc bit on the wire
    send_ulpi_packet();
    random_payload();
    build_data(PID_DATA1, -1);
    send_ulpi_packet();
    settle();
    check_count("crc_err pulses", 1, crc_cnt);
    check_count("beat count", 0, beat_q.size());
    test_name = "other_addr";
    clear_monitor();
    build_token(PID_OUT, {4'd2, DEV_ADDR ^ 7'h01});
    send_ulpi_packet();
    build_data(PID_DATA1, -1);
    send_ulpi_packet();
    settle();
    check_count("crc_err pulses", 0, crc_cnt);
    check_count("beat count", 0, beat_q.size());
  endtask

  task automatic test_bad_pid();
    test_name = "bad_pid";
    clear_monitor();
    build_token(PID_OUT, {4'd2, DEV_ADDR});  // armed, so a leak would show as beats
    send_ulpi_packet();
    pkt.delete();
    pkt.push_back(8'h33);  // 3 over 3, not complements
    pkt.push_back(8'h12);
    pkt.push_back(8'h34);
    pkt.push_back(8'h56);
    pkt.push_back(8'h78);
    send_ulpi_packet();
    settle();
    check_count("pid_err pulses", 1, pid_cnt);
    check_count("crc_err pulses", 0, crc_cnt);
    check_count("beat count", 0, beat_q.size());
  endtask

  task automatic test_data_crc_err();
    test_name = "data_crc16_err";
    clear_monitor();
    random_payload();
    send_out_data(PID_DATA0, $unsigned($random(seed)) % exp_q.size());
    wait_for_tlast();
    check_payload(4'd2);  // flipped byte still delivered
    check_count("crc_err pulses", 1, crc_cnt);
  endtask

  task automatic test_sof();
    logic [10:0] frame;
    test_name = "sof";
    clear_monitor();
    frame = $random(seed);
    build_token(PID_SOF, frame);
    send_ulpi_packet();
    settle();
    check_count("sof pulses", 1, frame_q.size());
    check_frame(frame, frame_q[0]);
    check_count("beat count", 0, beat_q.size());
    check_count("crc_err pulses", 0, crc_cnt);
  endtask

  task automatic test_overflow();
    test_name = "overflow_drop";
    check_flag("overflow_o", 1'b0, overflow_o);  // nothing dropped so far
    @(posedge clock);
    m_axis_tready <= 1'b0;
    clear_monitor();
    random_payload();
    send_out_data(PID_DATA0, -1);
    settle();
    check_flag("overflow_o", 1'b1, overflow_o);
    test_name = "overflow_sticky";
    @(posedge clock);
    m_axis_tready <= 1'b1;
    clear_monitor();
    random_payload();
    send_out_data(PID_DATA0, -1);
    wait_for_tlast();
    check_payload(4'd2);
    check_flag("overflow_o", 1'b1, overflow_o);
  endtask

  initial begin
    areset_n      = 1'b0;
    ulpi_dir      = 1'b0;
    ulpi_nxt      = 1'b0;
    ulpi_data     = 8'h00;
    m_axis_tready = 1'b1;
    clear_monitor();
    repeat (5) @(posedge clock);
    areset_n <= 1'b1;
    @(posedge clock);
    test_out_data();
    test_token_reject();
    test_bad_pid();
    test_data_crc_err();
    test_sof();
    test_overflow();
    $display("Verification passed");
    $finish;
  end

endmodule
